// File: Bender.yml
package:
  name: mem_subsys

sources:
  - logic/bus_pkg.sv
  - logic/check_pkg.sv
  - logic/axil_mem_port.sv
  - logic/data_ram.sv
  - logic/result_checker.sv
  - logic/mem_subsys_top.sv
  - target: test
    files:
      - bench/tb_mem_subsys.sv

// File: bench/mem_subsys_patterns.txt
# op addr data strb resp expect, all hex; W and X ignore expect, R expects rdata
# S reads status after data idle cycles, expect is {finish, error_num}
S 404 0 0 0 0ff
W 400 00001234 f 0 0
S 404 3 0 0 0ff
W 000 11223344 f 0 0
W 004 a5a5a5a5 f 0 0
W 3fc deadbeef f 0 0
W 004 00cc0011 5 0 0
W 3fc 0000ff00 2 0 0
R 000 0 0 0 11223344
R 004 0 0 0 a5cca511
R 3fc 0 0 0 deadffef
W 408 55555555 f 2 0
W 10000000 66666666 f 2 0
R 800 0 0 2 0
R 000 0 0 0 11223344
W 404 12345678 f 0 0
R 400 0 0 0 0
W 400 00000168 f 0 0
W 400 00009d80 f 0 0
W 400 00000001 f 0 0
W 400 00000d5d f 0 0
S 404 0 0 0 100
S 404 5 0 0 100
X 0 0 0 0 0
S 404 0 0 0 0ff
W 400 00000168 f 0 0
W 400 00000007 f 0 0
W 400 00000002 f 0 0
W 400 00000d5d f 0 0
S 404 0 0 0 102
W 400 00000168 f 0 0
W 400 00009d80 f 0 0
S 404 4 0 0 102
R 004 0 0 0 a5cca511

// File: bench/tb_mem_subsys.sv
module tb_mem_subsys;
	import bus_pkg::*;
	import check_pkg::*;

	localparam int timeout_cycles = 100;

	logic clk;
	logic rst;
	axil_req_t req;
	axil_rsp_t rsp;
	checker_status_t status;

	logic [31:0] lfsr;
	int errors;
	int timeouts;
	int checks;
	int lines_run;
	bit hung;
	bit dur_known;
	logic [15:0] last_dur;

	mem_subsys_top i_dut (
		.clk(clk),
		.rst(rst),
		.req(req),
		.rsp(rsp),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic resp_valid(input bit write_dir);
		return write_dir ? rsp.bvalid : rsp.rvalid;
	endfunction

	// two lfsr bits give 0 to 3 cycles
	task automatic draw_delay(output int cycles);
		cycles = 0;
		repeat (2) begin
			lfsr = lfsr_step(lfsr);
			cycles = (cycles << 1) | lfsr[0];
		end
	endtask

	task automatic note_timeout(input string what);
		$display("timed out after %0d cycles waiting for %s", timeout_cycles, what);
		timeouts++;
		hung = 1'b1;
	endtask

	task automatic check_resp(input string name, input resp_e exp, input resp_e act);
		checks++;
		if (act !== exp) begin
			$display("Fail %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			$display("Fail %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_status(input string name, input checker_status_t exp,
			input checker_status_t act, input bit exact);
		checks++;
		if (act.finish !== exp.finish) begin
			$display("Fail %s.finish: expected %h, got %h", name, exp.finish, act.finish);
			errors++;
		end
		if (act.error_num !== exp.error_num) begin
			$display("Fail %s.error_num: expected %h, got %h", name, exp.error_num,
				act.error_num);
			errors++;
		end
		if (exact && act.duration !== exp.duration) begin
			$display("Fail %s.duration: expected %h, got %h", name, exp.duration,
				act.duration);
			errors++;
		end else if (!exact && act.duration == 16'd0) begin
			$display("%s shows a zero duration after the run finished", name);
			errors++;
		end
	endtask

	task automatic apply_reset();
		rst = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b1;
		dur_known = 1'b0;
	endtask

	task automatic wait_addr_ready(input bit write_dir);
		int cnt;
		bit taken;
		cnt = 0;
		taken = 1'b0;
		while (!taken && cnt < timeout_cycles) begin
			@(posedge clk);   // ready as seen by this edge
			taken = write_dir ? (rsp.awready && rsp.wready) : rsp.arready;
			cnt++;
		end
		if (!taken)
			note_timeout(write_dir ? "awready and wready" : "arready");
	endtask

	// waits for valid and then holds ready off for a random delay
	task automatic accept_response(input bit write_dir);
		int cnt;
		int delay;
		cnt = 0;
		while (!hung && !resp_valid(write_dir) && cnt < timeout_cycles) begin
			@(negedge clk);
			cnt++;
		end
		if (!hung && !resp_valid(write_dir))
			note_timeout(write_dir ? "bvalid" : "rvalid");
		if (!hung) begin
			draw_delay(delay);
			repeat (delay) begin
				@(negedge clk);
				if (!resp_valid(write_dir)) begin
					$display("%s dropped before the master accepted it",
						write_dir ? "bvalid" : "rvalid");
					errors++;
				end
			end
			if (write_dir)
				req.bready = 1'b1;
			else
				req.rready = 1'b1;
		end
	endtask

	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output resp_e resp);
		@(negedge clk);
		req.awaddr = addr;
		req.wdata = data;
		req.wstrb = strb;
		req.awvalid = 1'b1;
		req.wvalid = 1'b1;
		wait_addr_ready(1'b1);
		@(negedge clk);
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		accept_response(1'b1);
		resp = rsp.bresp;
		@(negedge clk);
		req.bready = 1'b0;
		if (!hung)
			check_word("rsp.bvalid", 32'd0, rsp.bvalid);   // no second response
	endtask

	task automatic axil_read(input logic [31:0] addr, output resp_e resp,
			output logic [31:0] data);
		@(negedge clk);
		req.araddr = addr;
		req.arvalid = 1'b1;
		wait_addr_ready(1'b0);
		@(negedge clk);
		req.arvalid = 1'b0;
		accept_response(1'b0);
		resp = rsp.rresp;
		data = rsp.rdata;
		@(negedge clk);
		req.rready = 1'b0;
		if (!hung)
			check_word("rsp.rvalid", 32'd0, rsp.rvalid);
	endtask

	task automatic run_line(input string line);
		byte op;
		int n;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [1:0] resp_val;
		logic [31:0] expect_val;
		resp_e got_resp;
		logic [31:0] got_word;
		checker_status_t exp_st;
		checker_status_t read_st;
		n = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, resp_val, expect_val);
		if (n != 6) begin
			$display("pattern line could not be parsed: %s", line);
			errors++;
		end else begin
			lines_run++;
			case (op)
				"W": begin
					axil_write(addr, data, strb, got_resp);
					check_resp("rsp.bresp", resp_e'(resp_val), got_resp);
				end
				"R": begin
					axil_read(addr, got_resp, got_word);
					check_resp("rsp.rresp", resp_e'(resp_val), got_resp);
					check_word("rsp.rdata", expect_val, got_word);
				end
				"S": begin
					repeat (data) @(negedge clk);   // idle gap before the read
					axil_read(addr, got_resp, got_word);
					check_resp("rsp.rresp", resp_e'(resp_val), got_resp);
					read_st.finish = got_word[31];
					read_st.error_num = got_word[23:16];
					read_st.duration = got_word[15:0];
					exp_st.finish = expect_val[8];
					exp_st.error_num = expect_val[7:0];
					exp_st.duration = exp_st.finish ? last_dur : 16'd0;
					check_status("rsp.rdata", exp_st, read_st, !exp_st.finish || dur_known);
					if (exp_st.finish && !dur_known) begin
						last_dur = read_st.duration;
						dur_known = 1'b1;
						exp_st.duration = last_dur;
					end
					check_status("status", exp_st, status, 1'b1);
				end
				"X": apply_reset();
				default: begin
					$display("unknown operation %c in the pattern file", op);
					errors++;
				end
			endcase
		end
	endtask

	initial begin
		int fd;
		string line;
		rst = 1'b0;
		req = '0;
		lfsr = 32'hae3f_1276;
		errors = 0;
		timeouts = 0;
		checks = 0;
		lines_run = 0;
		hung = 1'b0;
		dur_known = 1'b0;
		last_dur = '0;
		apply_reset();
		fd = $fopen("bench/mem_subsys_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file");
			errors++;
		end else begin
			while (!hung && $fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#")
					run_line(line);
			end
			$fclose(fd);
		end
		$display("pattern lines %0d, checks %0d, errors %0d, timeouts %0d",
			lines_run, checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && lines_run > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: files.f
logic/bus_pkg.sv
logic/check_pkg.sv
logic/axil_mem_port.sv
logic/data_ram.sv
logic/result_checker.sv
logic/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// File: logic/axil_mem_port.sv
module axil_mem_port (
	input logic clk,
	input logic rst,
	input bus_pkg::axil_req_t req,
	output bus_pkg::axil_rsp_t rsp,
	output bus_pkg::mem_access_t access,
	input logic [bus_pkg::data_width-1:0] ram_rdata,
	input check_pkg::checker_status_t status
);
	import bus_pkg::*;

	logic wr_take;
	logic rd_take;
	logic wr_busy;
	logic rd_busy;
	logic bvalid;
	resp_e bresp;
	logic rd_pipe;
	target_e rd_tgt;
	logic rvalid;
	resp_e rresp;
	logic [data_width-1:0] rdata;

	function automatic target_e decode(input logic [addr_width-1:0] addr);
		target_e tgt;
		if (addr < ram_words * strb_width)
			tgt = tgt_ram;
		else if (addr == test_port_addr)
			tgt = tgt_test;
		else if (addr == status_addr)
			tgt = tgt_status;
		else
			tgt = tgt_none;
		return tgt;
	endfunction

	assign wr_take = req.awvalid && req.wvalid && !wr_busy;   // aw and w taken together
	assign rd_take = req.arvalid && !rd_busy && !wr_take;      // write wins the access slot

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			access <= '0;
		end else if (wr_take) begin
			access <= '{
				valid: 1'b1,
				write: 1'b1,
				target: decode(req.awaddr),
				index: req.awaddr[word_lsb +: index_width],
				wdata: req.wdata,
				wstrb: req.wstrb
			};
		end else if (rd_take) begin
			access <= '{
				valid: 1'b1,
				write: 1'b0,
				target: decode(req.araddr),
				index: req.araddr[word_lsb +: index_width],
				wdata: '0,
				wstrb: '0
			};
		end else begin
			access.valid <= 1'b0;
		end
	end

	// busy from handshake until the response is accepted
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_busy <= 1'b0;
			rd_busy <= 1'b0;
		end else begin
			if (wr_take)
				wr_busy <= 1'b1;
			else if (bvalid && req.bready)
				wr_busy <= 1'b0;
			if (rd_take)
				rd_busy <= 1'b1;
			else if (rvalid && req.rready)
				rd_busy <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bvalid <= 1'b0;
			rd_pipe <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (access.valid && access.write)
				bvalid <= 1'b1;
			else if (req.bready)
				bvalid <= 1'b0;
			rd_pipe <= access.valid && !access.write;   // ram word arrives next cycle
			if (rd_pipe)
				rvalid <= 1'b1;
			else if (req.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (access.valid && access.write) begin
			if (access.target == tgt_none)
				bresp <= resp_slverr;
			else
				bresp <= resp_okay;
		end
		if (access.valid && !access.write)
			rd_tgt <= access.target;
		if (rd_pipe) begin
			case (rd_tgt)
				tgt_ram: begin
					rdata <= ram_rdata;
					rresp <= resp_okay;
				end
				tgt_status: begin
					rdata <= {status.finish, 7'd0, status.error_num, status.duration};
					rresp <= resp_okay;
				end
				tgt_test: begin
					rdata <= '0;   // test port reads as zero
					rresp <= resp_okay;
				end
				default: begin
					rdata <= '0;
					rresp <= resp_slverr;
				end
			endcase
		end
	end

	assign rsp = '{
		awready: wr_take,
		wready: wr_take,
		bresp: bresp,
		bvalid: bvalid,
		arready: rd_take,
		rdata: rdata,
		rresp: rresp,
		rvalid: rvalid
	};

endmodule

// File: logic/bus_pkg.sv
package bus_pkg;

	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;
	localparam int word_lsb = $clog2(strb_width);
	localparam int ram_words = 256;
	localparam int index_width = $clog2(ram_words);

	localparam logic [addr_width-1:0] test_port_addr = 32'h0000_0400;
	localparam logic [addr_width-1:0] status_addr = 32'h0000_0404;

	typedef enum logic [1:0] {
		tgt_ram,
		tgt_test,
		tgt_status,
		tgt_none
	} target_e;

	typedef enum logic [1:0] {
		resp_okay = 2'd0,
		resp_slverr = 2'd2
	} resp_e;

	// master side of the AXI4-Lite port
	typedef struct packed {
		logic [addr_width-1:0] awaddr;
		logic awvalid;
		logic [data_width-1:0] wdata;
		logic [strb_width-1:0] wstrb;
		logic wvalid;
		logic bready;
		logic [addr_width-1:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	// slave side
	typedef struct packed {
		logic awready;
		logic wready;
		resp_e bresp;
		logic bvalid;
		logic arready;
		logic [data_width-1:0] rdata;
		resp_e rresp;
		logic rvalid;
	} axil_rsp_t;

	typedef struct packed {
		logic valid;
		logic write;
		target_e target;
		logic [index_width-1:0] index;   // word index into the ram
		logic [data_width-1:0] wdata;
		logic [strb_width-1:0] wstrb;
	} mem_access_t;

endpackage

// File: logic/check_pkg.sv
package check_pkg;

	typedef enum logic [1:0] {
		st_idle,
		st_check,
		st_report
	} check_state_e;

	// status word holds finish at 31 then error_num at 23:16 and duration at 15:0
	typedef struct packed {
		logic finish;
		logic [7:0] error_num;
		logic [15:0] duration;
	} checker_status_t;

	localparam logic [31:0] begin_symbol = 32'h0000_0168;
	localparam logic [31:0] end_symbol = 32'h0000_0D5D;

	localparam int expect_count = 3;
	localparam int expect_idx_width = $clog2(expect_count + 1);

	// entry 0 is compared first
	localparam logic [expect_count-1:0][31:0] expect_table = {
		end_symbol,
		32'd1,
		32'd40320
	};

endpackage

// File: logic/data_ram.sv
module data_ram (
	input logic clk,
	input bus_pkg::mem_access_t access,
	output logic [bus_pkg::data_width-1:0] rdata
);
	import bus_pkg::*;

	logic [data_width-1:0] mem [ram_words];
	logic hit;

	assign hit = access.valid && access.target == tgt_ram;

	// byte lanes written under wstrb
	always_ff @(posedge clk) begin
		if (hit && access.write) begin
			for (int lane = 0; lane < strb_width; lane++) begin
				if (access.wstrb[lane])
					mem[access.index][lane*8 +: 8] <= access.wdata[lane*8 +: 8];
			end
		end
	end

	// registered read held until the next ram read
	always_ff @(posedge clk) begin
		if (hit && !access.write)
			rdata <= mem[access.index];
	end

endmodule

// File: logic/mem_subsys_top.sv
module mem_subsys_top (
	input logic clk,
	input logic rst,
	input bus_pkg::axil_req_t req,
	output bus_pkg::axil_rsp_t rsp,
	output check_pkg::checker_status_t status
);
	import bus_pkg::*;

	mem_access_t access;
	logic [data_width-1:0] ram_rdata;

	axil_mem_port i_port (
		.clk(clk),
		.rst(rst),
		.req(req),
		.rsp(rsp),
		.access(access),
		.ram_rdata(ram_rdata),
		.status(status)
	);

	data_ram i_ram (
		.clk(clk),
		.access(access),
		.rdata(ram_rdata)
	);

	// also feeds the status read path of the port
	result_checker i_checker (
		.clk(clk),
		.rst(rst),
		.access(access),
		.status(status)
	);

endmodule

// File: logic/result_checker.sv
module result_checker (
	input logic clk,
	input logic rst,
	input bus_pkg::mem_access_t access,
	output check_pkg::checker_status_t status
);
	import bus_pkg::*;
	import check_pkg::*;

	check_state_e state;
	check_state_e state_nxt;
	logic [expect_idx_width-1:0] idx;
	logic [expect_idx_width-1:0] idx_nxt;
	logic [7:0] err_cnt;
	logic [7:0] err_nxt;
	logic [15:0] dur_cnt;
	logic [15:0] dur_nxt;
	logic test_wr;

	assign test_wr = access.valid && access.write && access.target == tgt_test;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
			idx <= '0;
			err_cnt <= 8'hff;   // no run yet
			dur_cnt <= '0;
		end else begin
			state <= state_nxt;
			idx <= idx_nxt;
			err_cnt <= err_nxt;
			dur_cnt <= dur_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		idx_nxt = idx;
		err_nxt = err_cnt;
		dur_nxt = dur_cnt;
		case (state)
			st_idle: begin
				if (test_wr && access.wdata == begin_symbol) begin
					state_nxt = st_check;
					idx_nxt = '0;
					err_nxt = '0;
					dur_nxt = '0;
				end
			end
			st_check: begin
				dur_nxt = dur_cnt + 16'd1;
				if (test_wr) begin
					idx_nxt = idx + 1'b1;
					if (access.wdata != expect_table[idx])
						err_nxt = err_cnt + 8'd1;
					if (idx == expect_count - 1)
						state_nxt = st_report;   // table exhausted
				end
			end
			default: begin
				// report holds every value until reset
			end
		endcase
	end

	assign status = '{
		finish: state == st_report,
		error_num: err_cnt,
		duration: dur_cnt
	};

endmodule
